// ==== common/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// data path and address width
`define MIPS_WORD_BITS 32

// architectural registers, r0 included
`define MIPS_REG_COUNT 32

// data memory words, indexed by address bits 7:2
`define MIPS_DMEM_WORDS 64

`endif

// ==== common/mips_pkg.sv ====
`include "mips_params.svh"

package mips_pkg;

        typedef logic [`MIPS_WORD_BITS-1:0] wordT;

        ////////////////////
        // instruction fields
        ////////////////////
        typedef enum logic [5:0] {
                rType = 6'b000000,
                j     = 6'b000010,
                beq   = 6'b000100,
                bne   = 6'b000101,
                addi  = 6'b001000,
                slti  = 6'b001010,
                andi  = 6'b001100,
                ori   = 6'b001101,
                xori  = 6'b001110,
                lui   = 6'b001111,
                lw    = 6'b100011,
                sw    = 6'b101011
        } opcodeT;

        typedef enum logic [5:0] {
                fnAdd = 6'b100000,
                fnSub = 6'b100010,
                fnAnd = 6'b100100,
                fnOr  = 6'b100101,
                fnSlt = 6'b101010
        } functT;

        typedef enum logic [2:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluXor,
                aluSlt,         // signed compare
                aluLui          // b low half into upper 16 bits
        } aluOpT;

        typedef enum logic [1:0] {
                fetchReq,
                fetchWaitAckLow,
                execute
        } fetchStateT;

endpackage

// ==== common/ctrl_if.sv ====
`timescale 1ns/100ps

interface ctrlIf;

        mips_pkg::opcodeT opcode;       // instr[31:26]
        mips_pkg::functT  funct;        // instr[5:0]
        logic             regDst;       // write rd, not rt
        logic             aluSrc;       // immediate as operand b
        logic             memToReg;     // write back load data
        logic             regWrite;
        logic             memWrite;
        logic             branch;
        logic             branchNe;     // take on not-equal
        logic             jump;
        logic             signExt;      // else zero-extend
        mips_pkg::aluOpT  aluOp;

        modport controller (
                input  opcode, funct,
                output regDst, aluSrc, memToReg, regWrite, memWrite,
                output branch, branchNe, jump, signExt, aluOp
        );

        modport datapath (
                output opcode, funct,
                input  regDst, aluSrc, memToReg, regWrite, memWrite,
                input  branch, branchNe, jump, signExt, aluOp
        );

endinterface

// ==== src/controller.sv ====
`timescale 1ns/100ps

module controller (
        ctrlIf.controller ctrl
);

        always_comb begin
                // unknown opcodes fall through as a no-op
                ctrl.regDst   = 1'b0;
                ctrl.aluSrc   = 1'b0;
                ctrl.memToReg = 1'b0;
                ctrl.regWrite = 1'b0;
                ctrl.memWrite = 1'b0;
                ctrl.branch   = 1'b0;
                ctrl.branchNe = 1'b0;
                ctrl.jump     = 1'b0;
                ctrl.signExt  = 1'b1;
                ctrl.aluOp    = mips_pkg::aluAdd;

                case (ctrl.opcode)
                        mips_pkg::rType: begin
                                ctrl.regDst   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                case (ctrl.funct)
                                        mips_pkg::fnAdd: ctrl.aluOp = mips_pkg::aluAdd;
                                        mips_pkg::fnSub: ctrl.aluOp = mips_pkg::aluSub;
                                        mips_pkg::fnAnd: ctrl.aluOp = mips_pkg::aluAnd;
                                        mips_pkg::fnOr:  ctrl.aluOp = mips_pkg::aluOr;
                                        mips_pkg::fnSlt: ctrl.aluOp = mips_pkg::aluSlt;
                                        default:         ctrl.regWrite = 1'b0;  // no-op funct
                                endcase
                        end
                        mips_pkg::addi, mips_pkg::slti, mips_pkg::lui: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                if (ctrl.opcode == mips_pkg::slti)
                                        ctrl.aluOp = mips_pkg::aluSlt;
                                else if (ctrl.opcode == mips_pkg::lui)
                                        ctrl.aluOp = mips_pkg::aluLui;
                        end
                        mips_pkg::andi, mips_pkg::ori, mips_pkg::xori: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.signExt  = 1'b0;           // logical imm is zero-extended
                                if (ctrl.opcode == mips_pkg::andi)
                                        ctrl.aluOp = mips_pkg::aluAnd;
                                else if (ctrl.opcode == mips_pkg::ori)
                                        ctrl.aluOp = mips_pkg::aluOr;
                                else
                                        ctrl.aluOp = mips_pkg::aluXor;
                        end
                        mips_pkg::lw: begin
                                ctrl.aluSrc   = 1'b1;           // base + offset
                                ctrl.memToReg = 1'b1;
                                ctrl.regWrite = 1'b1;
                        end
                        mips_pkg::sw: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.memWrite = 1'b1;
                        end
                        mips_pkg::beq, mips_pkg::bne: begin
                                ctrl.branch   = 1'b1;
                                ctrl.branchNe = (ctrl.opcode == mips_pkg::bne);
                                ctrl.aluOp    = mips_pkg::aluSub;   // zero flag means equal
                        end
                        mips_pkg::j: begin
                                ctrl.jump     = 1'b1;
                        end
                        default: begin
                                ctrl.regWrite = 1'b0;
                        end
                endcase
        end

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module reg_file (
        input  logic           clk,
        input  logic           arstN,
        input  logic [4:0]     rdAddrA,
        input  logic [4:0]     rdAddrB,
        output mips_pkg::wordT rdDataA,
        output mips_pkg::wordT rdDataB,
        input  logic           wrEn,
        input  logic [4:0]     wrAddr,
        input  mips_pkg::wordT wrData
);

        mips_pkg::wordT regs [`MIPS_REG_COUNT];

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        regs <= '{default: '0};
                end else if (wrEn && wrAddr != 5'd0) begin   // r0 stays zero
                        regs[wrAddr] <= wrData;
                end
        end

        assign rdDataA = regs[rdAddrA];      // combinational read
        assign rdDataB = regs[rdAddrB];

endmodule

// ==== core/alu.sv ====
`timescale 1ns/100ps

module alu (
        input  mips_pkg::aluOpT op,
        input  mips_pkg::wordT  a,
        input  mips_pkg::wordT  b,
        output mips_pkg::wordT  result,
        output logic            zero
);

        logic lessThan;

        assign lessThan = $signed(a) < $signed(b);

        always_comb begin
                case (op)
                        mips_pkg::aluAdd: result = a + b;
                        mips_pkg::aluSub: result = a - b;
                        mips_pkg::aluAnd: result = a & b;
                        mips_pkg::aluOr:  result = a | b;
                        mips_pkg::aluXor: result = a ^ b;
                        mips_pkg::aluSlt: result = {{($bits(result) - 1){1'b0}}, lessThan};
                        mips_pkg::aluLui: result = {b[15:0], 16'h0000};
                        default:          result = '0;
                endcase
        end

        // used by beq/bne
        assign zero = (result == '0);

endmodule

// ==== core/data_mem.sv ====
`timescale 1ns/100ps
`include "mips_params.svh"

module data_mem (
        input  logic           clk,
        input  mips_pkg::wordT addr,
        input  logic           wrEn,
        input  mips_pkg::wordT wrData,
        output mips_pkg::wordT rdData
);

        localparam int IdxBits = $clog2(`MIPS_DMEM_WORDS);

        mips_pkg::wordT mem [`MIPS_DMEM_WORDS];
        logic [IdxBits-1:0] wordIdx;

        assign wordIdx = addr[IdxBits+1:2];     // word aligned

        always_ff @(posedge clk) begin
                if (wrEn)
                        mem[wordIdx] <= wrData;
        end

        assign rdData = mem[wordIdx];

endmodule

// ==== core/datapath.sv ====
`timescale 1ns/100ps

module datapath (
        input  logic           clk,
        input  logic           arstN,
        ctrlIf.datapath        ctrl,
        output logic           instrReq,
        output mips_pkg::wordT instrAddr,
        input  logic           instrAck,
        input  mips_pkg::wordT instrData,
        output logic           wbValid,
        output logic [4:0]     wbReg,
        output mips_pkg::wordT wbData
);

        mips_pkg::fetchStateT state;
        mips_pkg::wordT pc;
        mips_pkg::wordT instr;          // captured on first ack
        mips_pkg::wordT pcPlus4;
        mips_pkg::wordT immExt;
        mips_pkg::wordT branchTarget;
        mips_pkg::wordT jumpTarget;
        mips_pkg::wordT nextPc;
        mips_pkg::wordT rdDataA;
        mips_pkg::wordT rdDataB;
        mips_pkg::wordT aluB;
        mips_pkg::wordT aluResult;
        mips_pkg::wordT memData;
        mips_pkg::wordT wrData;
        logic [4:0] wrAddr;
        logic aluZero;
        logic isExec;
        logic takeBranch;
        logic capture;

        ////////////////////
        // fetch handshake
        ////////////////////
        assign capture = (state == mips_pkg::fetchReq) && instrReq && instrAck;
        assign isExec  = (state == mips_pkg::execute);

        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        state    <= mips_pkg::fetchReq;
                        instrReq <= 1'b0;
                        pc       <= '0;
                end else begin
                        case (state)
                                mips_pkg::fetchReq: begin
                                        if (capture) begin
                                                instrReq <= 1'b0;
                                                state    <= mips_pkg::fetchWaitAckLow;
                                        end else if (!instrAck) begin
                                                instrReq <= 1'b1;   // first request after reset
                                        end
                                end
                                mips_pkg::fetchWaitAckLow: begin
                                        if (!instrAck)
                                                state <= mips_pkg::execute;
                                end
                                mips_pkg::execute: begin
                                        pc       <= nextPc;
                                        instrReq <= 1'b1;           // next fetch right away
                                        state    <= mips_pkg::fetchReq;
                                end
                                default: state <= mips_pkg::fetchReq;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (capture)
                        instr <= instrData;
        end

        assign instrAddr   = pc;
        assign ctrl.opcode = mips_pkg::opcodeT'(instr[31:26]);
        assign ctrl.funct  = mips_pkg::functT'(instr[5:0]);

        ////////////////////
        // execute
        ////////////////////
        assign immExt = ctrl.signExt ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
        assign aluB   = ctrl.aluSrc ? immExt : rdDataB;
        assign wrAddr = ctrl.regDst ? instr[15:11] : instr[20:16];
        assign wrData = ctrl.memToReg ? memData : aluResult;

        reg_file uRegFile (
                .clk(clk), .arstN(arstN),
                .rdAddrA(instr[25:21]), .rdAddrB(instr[20:16]),
                .rdDataA(rdDataA), .rdDataB(rdDataB),
                .wrEn(isExec && ctrl.regWrite), .wrAddr(wrAddr), .wrData(wrData)
        );

        alu uAlu (.op(ctrl.aluOp), .a(rdDataA), .b(aluB), .result(aluResult), .zero(aluZero));

        data_mem uDataMem (
                .clk(clk), .addr(aluResult), .wrEn(isExec && ctrl.memWrite),
                .wrData(rdDataB), .rdData(memData)
        );

        // next pc
        assign pcPlus4      = pc + 32'd4;
        assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
        assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
        assign takeBranch   = ctrl.branch && (ctrl.branchNe ? !aluZero : aluZero);
        assign nextPc       = ctrl.jump ? jumpTarget : (takeBranch ? branchTarget : pcPlus4);

        assign wbValid = isExec && ctrl.regWrite && (wrAddr != 5'd0);   // r0 writes not reported
        assign wbReg   = wrAddr;
        assign wbData  = wrData;

endmodule

// ==== src/mips_top.sv ====
`timescale 1ns/100ps

module mips_top (
        input  logic           clk,
        input  logic           arstN,
        output logic           instrReq,
        output mips_pkg::wordT instrAddr,
        input  logic           instrAck,
        input  mips_pkg::wordT instrData,
        output logic           wbValid,
        output logic [4:0]     wbReg,
        output mips_pkg::wordT wbData
);

        ctrlIf ctrlBus ();      // decoded control

        controller uCtrl (
                .ctrl(ctrlBus.controller)
        );

        datapath uDatapath (
                .clk(clk),
                .arstN(arstN),
                .ctrl(ctrlBus.datapath),
                .instrReq(instrReq),
                .instrAddr(instrAddr),
                .instrAck(instrAck),
                .instrData(instrData),
                .wbValid(wbValid),
                .wbReg(wbReg),
                .wbData(wbData)
        );

endmodule

// ==== test/mips_sva.sv ====
`timescale 1ns/100ps

module mips_sva (
        input logic                 clk,
        input logic                 arstN,
        input logic                 instrReq,
        input logic                 instrAck,
        input mips_pkg::wordT       instrAddr,
        input logic                 wbValid,
        input mips_pkg::fetchStateT state
);

        // no new request while the old ack is still up
        reqAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
                (!instrReq && instrAck) |=> !instrReq)
                else $error("instrReq rose while instrAck was high");

        addrStable: assert property (@(posedge clk) disable iff (!arstN)
                (instrReq && $past(instrReq)) |-> $stable(instrAddr))
                else $error("instrAddr changed during a request");

        wbOneCycle: assert property (@(posedge clk) disable iff (!arstN)
                wbValid |=> !wbValid)
                else $error("wbValid held longer than one cycle");

        // writeback only in the cycle right after the ack drop
        wbAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
                wbValid |-> !instrReq && !instrAck
                        && $past(state) == mips_pkg::fetchWaitAckLow)
                else $error("writeback outside the cycle after the ack drop");

endmodule

bind datapath mips_sva uSva (
        .clk(clk), .arstN(arstN),
        .instrReq(instrReq), .instrAck(instrAck), .instrAddr(instrAddr),
        .wbValid(wbValid), .state(state)
);

// ==== test/mips_tb.sv ====
`timescale 1ns/100ps

module mipsTb;

        typedef enum logic [1:0] {
                stepWb,                 // expect a register writeback
                stepNoWb,
                stepAddr                // expect no writeback and a given next fetch
        } stepKindT;

        typedef struct packed {
                stepKindT       kind;
                logic [4:0]     rd;
                mips_pkg::wordT instr;
                mips_pkg::wordT val;    // writeback value or next fetch address
        } stepT;

        logic           clk;
        logic           arstN;
        logic           instrReq;
        mips_pkg::wordT instrAddr;
        logic           instrAck;
        mips_pkg::wordT instrData;
        logic           wbValid;
        logic [4:0]     wbReg;
        mips_pkg::wordT wbData;

        stepT           steps [$];
        mips_pkg::wordT buildPc;        // pc of the next table entry
        mips_pkg::wordT expPc;          // fetch address expected at run time
        mips_pkg::wordT lfsr;

        mips_top dut (
                .clk(clk), .arstN(arstN),
                .instrReq(instrReq), .instrAddr(instrAddr),
                .instrAck(instrAck), .instrData(instrData),
                .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
        );

        always #50 clk = ~clk;

        ////////////////////
        // encoding and pc rules
        ////////////////////
        function automatic mips_pkg::wordT encI(mips_pkg::opcodeT op, logic [4:0] rs,
                                                logic [4:0] rt, logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic mips_pkg::wordT encR(mips_pkg::functT fn, logic [4:0] rs,
                                                logic [4:0] rt, logic [4:0] rd);
                return {mips_pkg::rType, rs, rt, rd, 5'd0, fn};
        endfunction

        function automatic mips_pkg::wordT sext(logic [15:0] imm);
                return {{16{imm[15]}}, imm};
        endfunction

        function automatic mips_pkg::wordT branchTo(logic [15:0] imm);
                return buildPc + 32'd4 + (sext(imm) << 2);
        endfunction

        function automatic mips_pkg::wordT jumpTo(logic [25:0] target);
                mips_pkg::wordT pcNext;
                pcNext = buildPc + 32'd4;
                return {pcNext[31:28], target, 2'b00};
        endfunction

        function automatic mips_pkg::wordT lfsrNext(mips_pkg::wordT s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        ////////////////////
        // table building
        ////////////////////
        task automatic addWb(input mips_pkg::wordT instr, input logic [4:0] rd,
                             input mips_pkg::wordT val);
                steps.push_back(stepT'{stepWb, rd, instr, val});
                buildPc = buildPc + 32'd4;
        endtask

        task automatic addNoWb(input mips_pkg::wordT instr);
                steps.push_back(stepT'{stepNoWb, 5'd0, instr, 32'd0});
                buildPc = buildPc + 32'd4;
        endtask

        task automatic addFlow(input mips_pkg::wordT instr, input mips_pkg::wordT next);
                steps.push_back(stepT'{stepAddr, 5'd0, instr, next});
                buildPc = next;
        endtask

        task automatic buildTable();
                buildPc = '0;
                addWb(encI(mips_pkg::addi, 5'd0, 5'd1, 16'h0005), 5'd1, 32'd5);
                addWb(encI(mips_pkg::addi, 5'd0, 5'd2, 16'hfffd), 5'd2, sext(16'hfffd));
                addWb(encI(mips_pkg::ori, 5'd0, 5'd3, 16'h8001), 5'd3, 32'h0000_8001);
                addWb(encI(mips_pkg::andi, 5'd2, 5'd4, 16'hf0f0), 5'd4,
                      sext(16'hfffd) & 32'h0000_f0f0);      // zero-extended mask
                addWb(encI(mips_pkg::xori, 5'd3, 5'd5, 16'hffff), 5'd5,
                      32'h0000_8001 ^ 32'h0000_ffff);
                addWb(encI(mips_pkg::slti, 5'd2, 5'd6, 16'h0001), 5'd6, 32'd1);  // -3 < 1
                addWb(encI(mips_pkg::lui, 5'd0, 5'd7, 16'h1234), 5'd7, 32'h1234_0000);
                addWb(encR(mips_pkg::fnAdd, 5'd1, 5'd2, 5'd8), 5'd8, 32'd2);
                addWb(encR(mips_pkg::fnSub, 5'd1, 5'd2, 5'd9), 5'd9, 32'd8);
                addWb(encR(mips_pkg::fnAnd, 5'd3, 5'd5, 5'd10), 5'd10, 32'd0);
                addWb(encR(mips_pkg::fnOr, 5'd3, 5'd5, 5'd11), 5'd11, 32'h0000_ffff);
                addWb(encR(mips_pkg::fnSlt, 5'd2, 5'd1, 5'd12), 5'd12, 32'd1);   // signed
                addWb(encR(mips_pkg::fnSlt, 5'd1, 5'd2, 5'd13), 5'd13, 32'd0);
                addNoWb(encR(mips_pkg::fnAdd, 5'd1, 5'd1, 5'd0));       // r0 target
                addNoWb(encI(mips_pkg::sw, 5'd0, 5'd7, 16'h0010));
                addWb(encI(mips_pkg::lw, 5'd0, 5'd14, 16'h0010), 5'd14, 32'h1234_0000);
                addFlow(encI(mips_pkg::beq, 5'd1, 5'd1, 16'h0002), branchTo(16'h0002));
                addFlow(encI(mips_pkg::beq, 5'd1, 5'd2, 16'h0005), buildPc + 32'd4);
                addFlow(encI(mips_pkg::bne, 5'd1, 5'd2, 16'hfffc), branchTo(16'hfffc));
                addFlow(encI(mips_pkg::bne, 5'd1, 5'd1, 16'h0003), buildPc + 32'd4);
                addFlow({mips_pkg::j, 26'h000_0040}, jumpTo(26'h000_0040));
                addFlow(32'hfc00_0000, buildPc + 32'd4);               // opcode 6'h3f
                addWb(encI(mips_pkg::addi, 5'd9, 5'd15, 16'h0007), 5'd15, 32'd15);
        endtask

        ////////////////////
        // checks
        ////////////////////
        task automatic abortRun(input string msg);
                $display("%s", msg);
                $display("Simulation failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic checkWb(input mips_pkg::wordT expData, input logic [4:0] expReg,
                               input mips_pkg::wordT gotData, input logic [4:0] gotReg);
                if (gotReg !== expReg)
                        abortRun($sformatf("ERROR at %0t: wbReg expected %0d, got %0d",
                                           $time, expReg, gotReg));
                if (gotData !== expData)
                        abortRun($sformatf("ERROR at %0t: wbData expected %h, got %h",
                                           $time, expData, gotData));
        endtask

        task automatic checkAddr(input mips_pkg::wordT expAddr, input mips_pkg::wordT gotAddr);
                if (gotAddr !== expAddr)
                        abortRun($sformatf("ERROR at %0t: instrAddr expected %h, got %h",
                                           $time, expAddr, gotAddr));
        endtask

        task automatic checkNoWb(input logic seen);
                if (seen !== 1'b0)
                        abortRun($sformatf("ERROR at %0t: wbValid expected 0, got %b",
                                           $time, seen));
        endtask

        task automatic checkBit(input string name, input logic expBit, input logic gotBit);
                if (gotBit !== expBit)
                        abortRun($sformatf("ERROR at %0t: %s expected %b, got %b",
                                           $time, name, expBit, gotBit));
        endtask

        ////////////////////
        // responder
        ////////////////////
        task automatic idleRandomCycles();
                int delay;
                delay = 0;
                repeat (2) begin
                        delay = delay * 2 + int'(lfsr[0]);
                        lfsr = lfsrNext(lfsr);
                end
                repeat (delay) @(negedge clk);
        endtask

        task automatic runStep(input int idx);
                logic seen;
                logic [4:0] gotReg;
                mips_pkg::wordT gotData;
                seen = 1'b0;
                gotReg = '0;
                gotData = '0;
                while (!instrReq)
                        @(negedge clk);
                checkAddr(expPc, instrAddr);
                idleRandomCycles();
                instrData = steps[idx].instr;
                instrAck = 1'b1;
                while (instrReq)
                        @(negedge clk);
                idleRandomCycles();             // late ack drop
                instrAck = 1'b0;
                do begin
                        @(negedge clk);
                        if (wbValid) begin
                                seen = 1'b1;
                                gotReg = wbReg;
                                gotData = wbData;
                        end
                end while (!instrReq);          // next request ends the step
                if (steps[idx].kind == stepWb) begin
                        if (!seen)
                                abortRun($sformatf("no writeback was reported for step %0d", idx));
                        checkWb(steps[idx].val, steps[idx].rd, gotData, gotReg);
                end else begin
                        checkNoWb(seen);
                end
                expPc = (steps[idx].kind == stepAddr) ? steps[idx].val : expPc + 32'd4;
        endtask

        initial begin
                clk = 1'b0;
                arstN = 1'b0;
                instrAck = 1'b0;
                instrData = '0;
                lfsr = 32'h3b65_1903;
                expPc = '0;
                buildTable();
                repeat (4) begin
                        @(negedge clk);
                        checkBit("instrReq", 1'b0, instrReq);
                        checkNoWb(wbValid);
                end
                arstN = 1'b1;
                for (int i = 0; i < steps.size(); i++)
                        runStep(i);
                checkAddr(expPc, instrAddr);    // fetch after the last step
                $display("Simulation passed");
                $finish;
        end

        initial begin
                #1;
                repeat (steps.size() * 12 + 6) @(posedge clk);
                $display("timeout: the core stopped before all %0d table steps ran", steps.size());
                $display("Simulation failed");
                $fatal(1, "watchdog expired");
        end

endmodule

// ==== compile.f ====
+incdir+common
common/mips_pkg.sv
common/ctrl_if.sv
src/controller.sv
core/reg_file.sv
core/alu.sv
core/data_mem.sv
core/datapath.sv
src/mips_top.sv
test/mips_sva.sv
test/mips_tb.sv

// ==== Makefile ====
BUILD := obj_dir
LOG   := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module mipsTb -Mdir $(BUILD)

run: compile
	./$(BUILD)/VmipsTb | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
